// File: all.f
source/screenPkg.sv
source/pixelPkg.sv
source/pixelScanner.sv
source/playButtonSprite.sv
source/menuCompositor.sv
source/menuScreenTop.sv
tests/menuScreenTb.sv

// File: source/menuCompositor.sv
`timescale 1ns/1ps

module menuCompositor (
  input  logic               clk,
  input  logic               rstN,
  input  logic               inValid,
  input  screenPkg::scanPos  inPos,
  input  logic               textHit,
  input  logic               iconHit,
  input  logic               selected,  // level from the menu input
  output pixelPkg::pixelBeat pixelOut
);
  import screenPkg::*;
  import pixelPkg::*;

  logic   frameBeat; // first pixel of a frame is entering
  logic   selLatch;  // selection held for the running frame
  logic   selNow;
  rgb565  colorNext;
  logic   validQ;
  scanPos posQ;
  rgb565  colorQ;

  assign frameBeat = inValid && inPos.frameStart;
  assign selNow    = frameBeat ? selected : selLatch; // new frame sees its own sample

  // icon over text over background
  always_comb begin
    if (iconHit) begin
      colorNext = selNow ? iconSelectedColor : iconColor;
    end else if (textHit) begin
      colorNext = textColor;
    end else begin
      colorNext = backgroundColor;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      selLatch <= 1'b0;
      validQ   <= 1'b0;
    end else begin
      if (frameBeat) begin
        selLatch <= selected; // only sampled at frame start, no mid-frame tearing
      end
      validQ <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    posQ   <= inPos;
    colorQ <= colorNext;
  end

  assign pixelOut = '{valid: validQ, pos: posQ, color: colorQ};

endmodule

// File: source/menuScreenTop.sv
`timescale 1ns/1ps

module menuScreenTop (
  input  logic               clk,
  input  logic               rstN,
  input  logic               creditReturn, // one pulse per beat taken by the buffer
  input  logic               selected,
  output pixelPkg::pixelBeat pixelOut
);
  import screenPkg::*;

  logic   issueValid;
  scanPos issuePos;   // position in the issue cycle
  logic   spriteValid;
  scanPos spritePos;  // position one cycle later, beside the hits
  logic   textHit;
  logic   iconHit;

  pixelScanner uScanner (
    .clk          (clk),
    .rstN         (rstN),
    .creditReturn (creditReturn),
    .issueValid   (issueValid),
    .pos          (issuePos)
  );

  playButtonSprite uSprite (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (issueValid),
    .inPos    (issuePos),
    .outValid (spriteValid),
    .outPos   (spritePos),
    .textHit  (textHit),
    .iconHit  (iconHit)
  );

  menuCompositor uCompositor (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (spriteValid),
    .inPos    (spritePos),
    .textHit  (textHit),
    .iconHit  (iconHit),
    .selected (selected),
    .pixelOut (pixelOut)
  );

endmodule

// File: source/pixelPkg.sv
package pixelPkg;

  // 5 bits red, 6 bits green, 5 bits blue
  typedef logic [15:0] rgb565;

  // menu palette
  localparam rgb565 backgroundColor   = 16'h0008; // dark navy
  localparam rgb565 textColor         = 16'hFFFF; // white lettering
  localparam rgb565 iconColor         = 16'h07E0; // green disc
  localparam rgb565 iconSelectedColor = 16'hFFE0; // yellow once chosen

  // receiver buffer depth, also the credit count after reset
  localparam int linkCredits = 8;

  // wide enough to hold linkCredits itself
  typedef logic [3:0] creditCount;

  // one beat on the link toward the display buffer
  typedef struct packed {
    logic              valid;
    screenPkg::scanPos pos;
    rgb565             color;
  } pixelBeat;

endpackage

// File: source/pixelScanner.sv
`timescale 1ns/1ps

module pixelScanner (
  input  logic              clk,
  input  logic              rstN,
  input  logic              creditReturn, // one slot freed at the receiver
  output logic              issueValid,
  output screenPkg::scanPos pos
);
  import screenPkg::*;
  import pixelPkg::*;

  xCoord      xPos;    // current column
  yCoord      yPos;    // current row
  creditCount credits; // free slots at the receiver
  logic       lastX;
  logic       lastY;
  logic       firstPix;

  assign lastX    = (xPos == xCoord'(screenWidth - 1));
  assign lastY    = (yPos == yCoord'(screenHeight - 1));
  assign firstPix = (xPos == '0) && (yPos == '0);

  // a position only goes out while a receiver slot is free
  assign issueValid = (credits != '0);

  assign pos = '{
    x:          xPos,
    y:          yPos,
    frameStart: firstPix,
    lineEnd:    lastX
  };

  // credit taken at issue, so nothing downstream ever has to stall
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      credits <= creditCount'(linkCredits); // receiver starts empty
    end else begin
      case ({issueValid, creditReturn})
        2'b10:   credits <= credits - 1'b1; // spent on this position
        2'b01:   credits <= credits + 1'b1; // beat consumed downstream
        default: credits <= credits;        // spend and return cancel out
      endcase
    end
  end

  // raster walk, advances once per issued position
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      xPos <= '0;
      yPos <= '0;
    end else if (issueValid) begin
      if (lastX) begin
        xPos <= '0; // wrap to next line
        if (lastY) begin
          yPos <= '0; // bottom reached, new frame
        end else begin
          yPos <= yPos + 1'b1;
        end
      end else begin
        xPos <= xPos + 1'b1;
      end
    end
  end

endmodule

// File: source/playButtonSprite.sv
`timescale 1ns/1ps

module playButtonSprite (
  input  logic              clk,
  input  logic              rstN,
  input  logic              inValid,
  input  screenPkg::scanPos inPos,
  output logic              outValid,
  output screenPkg::scanPos outPos,
  output logic              textHit,
  output logic              iconHit
);
  import screenPkg::*;

  logic       inBox;   // pixel lies inside the sprite box
  logic [5:0] rx;      // column relative to the box, 0..60
  logic [6:0] ry;      // row relative to the box, 0..69
  logic [6:0] my;      // icon row folded about centre row 52
  logic       textDet;
  logic       discDet;
  logic       cutDet;  // triangle cut out of the disc

  // true when v lies in lo..hi
  function automatic logic sp(input logic [5:0] v, input int lo, input int hi);
    return (v >= lo) && (v <= hi);
  endfunction

  assign inBox = (inPos.x >= spriteOriginX) && (inPos.x < spriteOriginX + spriteWidth)
              && (inPos.y >= spriteOriginY) && (inPos.y < spriteOriginY + spriteHeight);

  assign rx = 6'(inPos.x - spriteOriginX); // only meaningful when inBox
  assign ry = 7'(inPos.y - spriteOriginY);
  assign my = (ry <= 7'd52) ? ry : 7'd104 - ry; // disc is symmetric top to bottom

  // lettering, one row of spans per case item
  always_comb begin
    case (ry) inside
      0:       textDet = sp(rx, 9, 12) || sp(rx, 53, 53);
      1:       textDet = sp(rx, 8, 13) || sp(rx, 53, 53);
      2:       textDet = sp(rx, 7, 9) || sp(rx, 12, 14) || sp(rx, 53, 54);
      3:       textDet = sp(rx, 6, 8) || sp(rx, 13, 15) || sp(rx, 53, 54);
      4:       textDet = sp(rx, 6, 7) || sp(rx, 14, 15) || sp(rx, 53, 54);
      [5:6]:   textDet = sp(rx, 6, 7) || sp(rx, 15, 15) || sp(rx, 53, 54);
      [7:9]:   textDet = sp(rx, 6, 7) || sp(rx, 53, 54); // upright strokes only
      10:      textDet = sp(rx, 6, 7) || sp(rx, 9, 12) || sp(rx, 53, 54);
      11:      textDet = sp(rx, 6, 13) || sp(rx, 21, 22) || sp(rx, 24, 28)
                      || sp(rx, 36, 38) || sp(rx, 48, 54);
      12:      textDet = sp(rx, 6, 9) || sp(rx, 12, 14) || sp(rx, 22, 29)
                      || sp(rx, 37, 39) || sp(rx, 47, 54);
      13:      textDet = sp(rx, 6, 8) || sp(rx, 13, 15) || sp(rx, 22, 25) || sp(rx, 28, 30)
                      || sp(rx, 38, 39) || sp(rx, 46, 48) || sp(rx, 52, 54);
      14:      textDet = sp(rx, 6, 7) || sp(rx, 14, 15) || sp(rx, 22, 23) || sp(rx, 29, 30)
                      || sp(rx, 38, 39) || sp(rx, 45, 47) || sp(rx, 53, 54);
      15:      textDet = sp(rx, 6, 7) || sp(rx, 14, 15) || sp(rx, 22, 23) || sp(rx, 28, 30)
                      || sp(rx, 38, 39) || sp(rx, 45, 46) || sp(rx, 53, 54);
      16:      textDet = sp(rx, 6, 7) || sp(rx, 14, 15) || sp(rx, 22, 24) || sp(rx, 27, 29)
                      || sp(rx, 38, 39) || sp(rx, 45, 46) || sp(rx, 53, 54);
      17:      textDet = sp(rx, 6, 7) || sp(rx, 14, 15) || sp(rx, 22, 28)
                      || sp(rx, 38, 39) || sp(rx, 45, 46) || sp(rx, 53, 54);
      18:      textDet = sp(rx, 6, 7) || sp(rx, 14, 15) || sp(rx, 22, 23) || sp(rx, 25, 27)
                      || sp(rx, 38, 39) || sp(rx, 45, 46) || sp(rx, 53, 54);
      19:      textDet = sp(rx, 6, 7) || sp(rx, 14, 15) || sp(rx, 22, 23) || sp(rx, 30, 30)
                      || sp(rx, 38, 39) || sp(rx, 45, 47) || sp(rx, 53, 54);
      20:      textDet = sp(rx, 6, 7) || sp(rx, 14, 15) || sp(rx, 22, 24) || sp(rx, 29, 30)
                      || sp(rx, 38, 39) || sp(rx, 46, 48) || sp(rx, 52, 54);
      21:      textDet = sp(rx, 7, 7) || sp(rx, 14, 14) || sp(rx, 23, 29)
                      || sp(rx, 38, 39) || sp(rx, 47, 53);
      22:      textDet = sp(rx, 7, 7) || sp(rx, 14, 14) || sp(rx, 25, 28)
                      || sp(rx, 38, 39) || sp(rx, 48, 52);
      [23:27]: textDet = sp(rx, 38, 39); // descender
      [28:29]: textDet = sp(rx, 38, 38);
      default: textDet = 1'b0;
    endcase
  end

  // outline of the disc, upper half and middle band
  always_comb begin
    case (my) inside
      35:      discDet = sp(rx, 18, 42);
      36:      discDet = sp(rx, 11, 50);
      37:      discDet = sp(rx, 6, 54);
      38:      discDet = sp(rx, 3, 57);
      39:      discDet = sp(rx, 2, 58);
      [40:42]: discDet = sp(rx, 1, 59);
      [43:52]: discDet = sp(rx, 0, 60); // full width around the middle
      default: discDet = 1'b0;
    endcase
  end

  // play triangle, widest at the centre row
  always_comb begin
    case (my) inside
      43:      cutDet = sp(rx, 34, 37); // tip of the triangle
      44:      cutDet = sp(rx, 32, 38);
      45:      cutDet = sp(rx, 30, 38);
      46:      cutDet = sp(rx, 28, 38);
      47:      cutDet = sp(rx, 26, 38);
      48:      cutDet = sp(rx, 24, 38);
      49:      cutDet = sp(rx, 22, 38);
      50:      cutDet = sp(rx, 21, 38);
      [51:52]: cutDet = sp(rx, 20, 38);
      default: cutDet = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else begin
      outValid <= inValid;
    end
  end

  // hits travel with the position they belong to
  always_ff @(posedge clk) begin
    outPos  <= inPos;
    textHit <= inBox && textDet;
    iconHit <= inBox && discDet && !cutDet; // cutout shows background
  end

endmodule

// File: source/screenPkg.sv
package screenPkg;

  // visible area of the menu screen in pixels
  localparam int screenWidth  = 320;
  localparam int screenHeight = 240;

  // coordinate words, sized to the screen
  typedef logic [8:0] xCoord; // 0..319
  typedef logic [7:0] yCoord; // 0..239

  // top-left corner of the play-button box, roughly centred
  localparam xCoord spriteOriginX = 9'd125;
  localparam yCoord spriteOriginY = 8'd90;

  // extent of the box that holds lettering and icon
  localparam int spriteWidth  = 61; // icon reaches column 60
  localparam int spriteHeight = 70; // lettering rows 0..29, icon rows 35..69

  // one raster position as it travels down the pipeline
  typedef struct packed {
    xCoord x;
    yCoord y;
    logic  frameStart; // set at (0,0)
    logic  lineEnd;    // set at the last column
  } scanPos;

endpackage

// File: tests/menuScreenTb.sv
`timescale 1ns/1ps

module menuScreenTb;
  import screenPkg::*;
  import pixelPkg::*;

  // one entry of the probe table
  typedef struct packed {
    xCoord x;
    yCoord y;
    logic  frame;  // 0 or 1
    rgb565 color;  // expected colour at that pixel
  } probe;

  logic     clk;
  logic     rstN;
  logic     creditReturn;
  logic     selected;
  pixelBeat pixelOut;

  probe        probeTable[$];
  int          beatCount;   // valid beats seen on the link
  int          returnCount; // credits handed back
  int          frameNum;
  int          expX;
  int          expY;
  logic        returnsOn;   // credit returns withheld while 0
  logic [15:0] lfsrState;
  logic        takeBit;

  menuScreenTop dut (
    .clk          (clk),
    .rstN         (rstN),
    .creditReturn (creditReturn),
    .selected     (selected),
    .pixelOut     (pixelOut)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  // 16-bit galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic reportFail(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic checkEqual(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (expected === actual) else
      reportFail($sformatf("MISMATCH %s expected %0h actual %0h", name, expected, actual));
  endtask

  // positions relative to the sprite box origin
  task automatic addProbe(input int rx, input int ry, input int fr, input rgb565 c);
    probe p;
    p.x   = xCoord'(spriteOriginX + rx);
    p.y   = yCoord'(spriteOriginY + ry);
    p.frame = fr[0];
    p.color = c;
    probeTable.push_back(p);
  endtask

  // polls the beat count once per clock until target is reached
  task automatic waitBeats(input int target, input int maxCycles, input string what);
    int cycles;
    cycles = 0;
    while ((beatCount < target) && (cycles < maxCycles)) begin
      @(posedge clk);
      cycles++;
    end
    assert (beatCount >= target) else
      reportFail($sformatf("timeout while waiting for %s", what));
  endtask

  // credit return and selection driven on the rising edge
  always @(posedge clk) begin
    if (rstN) begin
      takeBit   = lfsrState[0]; // one bit per cycle
      lfsrState = lfsrStep(lfsrState);
      if (returnsOn && (beatCount > returnCount) && takeBit) begin
        creditReturn <= 1'b1;
        returnCount  = returnCount + 1;
      end else begin
        creditReturn <= 1'b0;
      end
      if (beatCount >= screenWidth) begin
        selected <= 1'b1; // set in mid frame 0 so only frame 1 picks it up
      end
    end
  end

  // raster and colour checker
  always @(negedge clk) begin
    if (rstN && pixelOut.valid) begin
      checkEqual("rasterX", expX, pixelOut.pos.x);
      checkEqual("rasterY", expY, pixelOut.pos.y);
      checkEqual("frameStart", (expX == 0) && (expY == 0), pixelOut.pos.frameStart);
      checkEqual("lineEnd", expX == screenWidth - 1, pixelOut.pos.lineEnd);
      if ((expX < spriteOriginX) || (expX >= spriteOriginX + spriteWidth)
          || (expY < spriteOriginY) || (expY >= spriteOriginY + spriteHeight)) begin
        checkEqual($sformatf("outside (%0d,%0d)", expX, expY), backgroundColor,
                   pixelOut.color);
      end
      for (int i = 0; i < probeTable.size(); i++) begin
        if ((probeTable[i].x == expX) && (probeTable[i].y == expY)
            && (probeTable[i].frame == frameNum)) begin
          checkEqual($sformatf("probe (%0d,%0d) frame %0d", expX, expY, frameNum),
                     probeTable[i].color, pixelOut.color);
        end
      end
      beatCount++;
      // next expected raster position
      if (expX == screenWidth - 1) begin
        expX = 0;
        if (expY == screenHeight - 1) begin
          expY = 0;
          frameNum++;
        end else begin
          expY++;
        end
      end else begin
        expX++;
      end
    end
    if (rstN) begin
      assert (beatCount - returnCount <= linkCredits) else
        reportFail("more beats outstanding than the receiver can hold");
    end
  end

  initial begin
    rstN         = 1'b0;
    creditReturn = 1'b0;
    selected     = 1'b0; // frame 0 unselected
    returnsOn    = 1'b0;
    lfsrState    = 16'd79;
    takeBit      = 1'b0;
    beatCount    = 0;
    returnCount  = 0;
    frameNum     = 0;
    expX         = 0;
    expY         = 0;

    for (int f = 0; f < 2; f++) begin
      addProbe(9, 0, f, textColor);   // top of the p bowl
      addProbe(53, 5, f, textColor);  // stem of the l
      addProbe(30, 69, f, f ? iconSelectedColor : iconColor); // bottom row of disc
      addProbe(30, 40, f, f ? iconSelectedColor : iconColor);
      addProbe(0, 43, f, f ? iconSelectedColor : iconColor);  // left edge of disc
      addProbe(35, 50, f, backgroundColor); // inside the triangle
      addProbe(0, 0, f, backgroundColor);   // box corner
      addProbe(175, 110, f, backgroundColor); // far from the sprite
    end

    repeat (16) @(posedge clk);
    rstN <= 1'b1;

    // pipeline is two deep so nothing is valid yet
    repeat (2) begin
      @(negedge clk);
      assert (!pixelOut.valid) else
        reportFail("valid beat appeared before the pipeline latency");
    end

    // returns withheld so the stream stops after the initial credits
    waitBeats(linkCredits, 50, "the first beats");
    repeat (12) @(posedge clk);
    assert (beatCount == linkCredits) else
      reportFail("beats kept coming with all credits spent");

    @(negedge clk);
    returnsOn = 1'b1;
    waitBeats(linkCredits + 1, 50, "the stream to resume after credit return");

    // two whole frames with selection set for frame 1
    waitBeats(2 * screenWidth * screenHeight, 1000000, "two full frames");

    $display("Done: no errors");
    $finish;
  end

endmodule
